//--- rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // instruction and halfword widths
    localparam int ilen     = 32;
    localparam int half_len = 16;

    // first fetch address out of reset
    localparam logic [ilen-1:0] reset_pc = 32'h0000_0000;

    // rv32i major opcodes produced by the expander
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    // aligner buffer occupancy
    typedef enum logic [0:0] {
        align_empty,
        align_full
    } align_state_e;

    // supported compressed forms
    // c.nop shares the c.addi encoding with rd = x0
    typedef enum logic [3:0] {
        rvc_addi,
        rvc_li,
        rvc_lui,
        rvc_mv,
        rvc_add,
        rvc_lw,
        rvc_sw,
        rvc_j,
        rvc_beqz,
        rvc_bnez,
        rvc_illegal
    } rvc_op_e;

endpackage

`default_nettype wire

//--- rtl/compressed_buffer.sv
`default_nettype none

module compressed_buffer (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic [fetch_pkg::ilen-1:0] fetch_word,
    input  logic                       ext_stall,
    output logic [fetch_pkg::ilen-1:0] align_inst,
    output logic                       align_valid,
    output logic                       align_compressed,
    output logic                       fetch_stall
);
    import fetch_pkg::*;

    align_state_e        state;
    align_state_e        state_next;
    logic [half_len-1:0] buf_half;
    logic                word_present;
    logic                buf_is_rvc;
    logic                load_buf;

    // all-zero word is a fetch bubble
    assign word_present = (fetch_word != '0);
    assign buf_is_rvc   = (buf_half[1:0] != 2'b11);

    // buffered half is a whole instruction, so the fetch word must be replayed
    assign fetch_stall = (state == align_full) && buf_is_rvc;

    always_comb begin
        align_inst = fetch_word;
        state_next = state;
        load_buf   = 1'b0;
        case (state)
            align_empty: begin
                if (fetch_word[1:0] != 2'b11) begin
                    // low half issues, upper half waits in the buffer
                    align_inst = {{half_len{1'b0}}, fetch_word[half_len-1:0]};
                    state_next = align_full;
                    load_buf   = 1'b1;
                end
            end
            align_full: begin
                if (buf_is_rvc) begin
                    align_inst = {{half_len{1'b0}}, buf_half};
                    state_next = align_empty;
                end else begin
                    // 32-bit instruction straddling two words
                    align_inst = {fetch_word[half_len-1:0], buf_half};
                    load_buf   = 1'b1;
                end
            end
            default: begin
                state_next = align_empty;
            end
        endcase
    end

    assign align_valid      = !ext_stall && (fetch_stall || word_present);
    assign align_compressed = (align_inst[1:0] != 2'b11);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= align_empty;
        end else if (align_valid) begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (align_valid && load_buf) begin
            buf_half <= fetch_word[ilen-1:half_len];
        end
    end

endmodule

`default_nettype wire

//--- rtl/rvc_expander.sv
`default_nettype none

module rvc_expander (
    input  logic [fetch_pkg::ilen-1:0] c_inst,
    output logic [fetch_pkg::ilen-1:0] x_inst,
    output logic                       illegal
);
    import fetch_pkg::*;

    rvc_op_e     op;
    logic [1:0]  quadrant;
    logic [2:0]  funct3;
    logic [4:0]  rd_full;
    logic [4:0]  rs2_full;
    logic [4:0]  low_prime;
    logic [4:0]  rs1_prime;
    logic [11:0] imm6_sx;
    logic [11:0] mem_off;
    logic [20:0] j_off;
    logic [12:0] b_off;

    assign quadrant = c_inst[1:0];
    assign funct3   = c_inst[15:13];
    assign rd_full  = c_inst[11:7];
    assign rs2_full = c_inst[6:2];

    // compact registers map onto x8..x15
    // bits 4:2 are rd' for c.lw and rs2' for c.sw
    assign low_prime = {2'b01, c_inst[4:2]};
    assign rs1_prime = {2'b01, c_inst[9:7]};

    // immediate rescrambling
    assign imm6_sx = {{7{c_inst[12]}}, c_inst[6:2]};
    assign mem_off = {5'b0, c_inst[5], c_inst[12:10], c_inst[6], 2'b00};
    assign j_off   = {{10{c_inst[12]}}, c_inst[8], c_inst[10:9], c_inst[6],
                      c_inst[7], c_inst[2], c_inst[11], c_inst[5:3], 1'b0};
    assign b_off   = {{5{c_inst[12]}}, c_inst[6:5], c_inst[2],
                      c_inst[11:10], c_inst[4:3], 1'b0};

    always_comb begin
        op = rvc_illegal;
        case (quadrant)
            2'b00: begin
                case (funct3)
                    3'b010:  op = rvc_lw;
                    3'b110:  op = rvc_sw;
                    default: op = rvc_illegal;
                endcase
            end
            2'b01: begin
                case (funct3)
                    3'b000:  op = rvc_addi;
                    3'b010:  op = rvc_li;
                    // rd = x2 here is c.addi16sp, not handled
                    3'b011:  op = (rd_full != 5'd2) ? rvc_lui : rvc_illegal;
                    3'b101:  op = rvc_j;
                    3'b110:  op = rvc_beqz;
                    3'b111:  op = rvc_bnez;
                    default: op = rvc_illegal;
                endcase
            end
            2'b10: begin
                // rs2 = x0 would be c.jr / c.jalr / c.ebreak
                if (funct3 == 3'b100 && rs2_full != 5'd0) begin
                    op = c_inst[12] ? rvc_add : rvc_mv;
                end
            end
            default: op = rvc_illegal;
        endcase
    end

    always_comb begin
        x_inst  = '0;
        illegal = 1'b0;
        if (quadrant == 2'b11) begin
            // already a full-width instruction
            x_inst = c_inst;
        end else begin
            case (op)
                rvc_addi: x_inst = {imm6_sx, rd_full, 3'b000, rd_full, opc_op_imm};
                rvc_li:   x_inst = {imm6_sx, 5'd0, 3'b000, rd_full, opc_op_imm};
                rvc_lui:  x_inst = {{8{c_inst[12]}}, imm6_sx, rd_full, opc_lui};
                rvc_mv:   x_inst = {7'b0, rs2_full, 5'd0, 3'b000, rd_full, opc_op};
                rvc_add:  x_inst = {7'b0, rs2_full, rd_full, 3'b000, rd_full, opc_op};
                rvc_lw:   x_inst = {mem_off, rs1_prime, 3'b010, low_prime, opc_load};
                rvc_sw: begin
                    x_inst = {mem_off[11:5], low_prime, rs1_prime, 3'b010,
                              mem_off[4:0], opc_store};
                end
                rvc_j: begin
                    x_inst = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                              5'd0, opc_jal};
                end
                rvc_beqz: begin
                    x_inst = {b_off[12], b_off[10:5], 5'd0, rs1_prime, 3'b000,
                              b_off[4:1], b_off[11], opc_branch};
                end
                rvc_bnez: begin
                    x_inst = {b_off[12], b_off[10:5], 5'd0, rs1_prime, 3'b001,
                              b_off[4:1], b_off[11], opc_branch};
                end
                default: illegal = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/pc_sequencer.sv
`default_nettype none

module pc_sequencer (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       align_valid,
    input  logic                       align_compressed,
    input  logic                       ext_stall,
    output logic [fetch_pkg::ilen-1:0] pc
);
    import fetch_pkg::*;

    logic [ilen-1:0] pc_step;

    // halfword step for compressed, word step otherwise
    assign pc_step = align_compressed ? 32'd2 : 32'd4;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pc <= reset_pc;
        end else if (align_valid && !ext_stall) begin
            pc <= pc + pc_step;
        end
    end

endmodule

`default_nettype wire

//--- rtl/id_latch.sv
`default_nettype none

module id_latch (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       ext_stall,
    input  logic                       align_valid,
    input  logic                       align_compressed,
    input  logic [fetch_pkg::ilen-1:0] x_inst,
    input  logic                       illegal,
    input  logic [fetch_pkg::ilen-1:0] pc,
    output logic                       id_valid,
    output logic [fetch_pkg::ilen-1:0] id_inst,
    output logic [fetch_pkg::ilen-1:0] id_pc,
    output logic                       id_compressed,
    output logic                       id_illegal
);

    // valid drops on idle cycles and holds while decode stalls
    always_ff @(posedge clk) begin
        if (!nrst) begin
            id_valid <= 1'b0;
        end else if (!ext_stall) begin
            id_valid <= align_valid;
        end
    end

    // instruction, address and flags move together on an issue
    always_ff @(posedge clk) begin
        if (!ext_stall && align_valid) begin
            id_inst       <= x_inst;
            id_pc         <= pc;
            id_compressed <= align_compressed;
            id_illegal    <= illegal;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_align_top.sv
`default_nettype none

module fetch_align_top (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic [fetch_pkg::ilen-1:0] fetch_word,
    input  logic                       ext_stall,
    output logic                       fetch_stall,
    output logic                       id_valid,
    output logic [fetch_pkg::ilen-1:0] id_inst,
    output logic [fetch_pkg::ilen-1:0] id_pc,
    output logic                       id_compressed,
    output logic                       id_illegal
);
    import fetch_pkg::*;

    logic [ilen-1:0] align_inst;
    logic            align_valid;
    logic            align_compressed;
    logic [ilen-1:0] x_inst;
    logic            illegal;
    logic [ilen-1:0] pc;

    compressed_buffer u_buffer (
        .clk              (clk),
        .nrst             (nrst),
        .fetch_word       (fetch_word),
        .ext_stall        (ext_stall),
        .align_inst       (align_inst),
        .align_valid      (align_valid),
        .align_compressed (align_compressed),
        .fetch_stall      (fetch_stall)
    );

    // expander and pc run side by side on the aligned instruction
    rvc_expander u_expander (
        .c_inst  (align_inst),
        .x_inst  (x_inst),
        .illegal (illegal)
    );

    pc_sequencer u_pc (
        .clk              (clk),
        .nrst             (nrst),
        .align_valid      (align_valid),
        .align_compressed (align_compressed),
        .ext_stall        (ext_stall),
        .pc               (pc)
    );

    id_latch u_latch (
        .clk              (clk),
        .nrst             (nrst),
        .ext_stall        (ext_stall),
        .align_valid      (align_valid),
        .align_compressed (align_compressed),
        .x_inst           (x_inst),
        .illegal          (illegal),
        .pc               (pc),
        .id_valid         (id_valid),
        .id_inst          (id_inst),
        .id_pc            (id_pc),
        .id_compressed    (id_compressed),
        .id_illegal       (id_illegal)
    );

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- test/fetch_align_assert.sv
`default_nettype none

module fetch_align_assert (
    input logic        clk,
    input logic        nrst,
    input logic        ext_stall,
    input logic        load,
    input logic        out_valid,
    input logic [65:0] out_bits
);
    timeunit 1ns;
    timeprecision 1ps;

    // a raised flag needs a load on the edge before it, or a decode stall holding it
    a_set_by_load: assert property (
        @(posedge clk) disable iff (!nrst)
            out_valid |-> ($past(load) || $past(out_valid && ext_stall))
    ) else $error("output high with no load and no held stall before it");

    // nothing presented in the cycle after reset
    a_idle_after_reset: assert property (
        @(posedge clk) !nrst |=> !out_valid
    ) else $error("valid high in the cycle after reset");

    // decode stall freezes the held state
    a_hold_under_stall: assert property (
        @(posedge clk) disable iff (!nrst) ext_stall |=> $stable({out_valid, out_bits})
    ) else $error("held outputs changed across an ext_stall cycle");

endmodule

// aligner stall flag follows a buffered half that was loaded and not yet issued
bind compressed_buffer fetch_align_assert u_align_assert (
    .clk       (clk),
    .nrst      (nrst),
    .ext_stall (ext_stall),
    .load      (align_valid && load_buf),
    .out_valid (fetch_stall),
    .out_bits  ({49'd0, state, buf_half})
);

// reset and hold of the decode-side outputs
bind id_latch fetch_align_assert u_latch_assert (
    .clk       (clk),
    .nrst      (nrst),
    .ext_stall (ext_stall),
    .load      (align_valid && !ext_stall),
    .out_valid (id_valid),
    .out_bits  ({id_inst, id_pc, id_compressed, id_illegal})
);

`default_nettype wire

//--- test/fetch_align_tb.sv
`default_nettype none

module fetch_align_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    typedef struct packed {
        logic [ilen-1:0] inst;
        logic            c;
        logic            i;
    } issue_t;

    // one fetch word and up to two instructions it releases
    typedef struct packed {
        logic [ilen-1:0] word;
        logic [1:0]      n;
        issue_t          e0;
        issue_t          e1;
    } row_t;

    typedef struct packed {
        logic [ilen-1:0] inst;
        logic [ilen-1:0] pc;
        logic            c;
        logic            i;
    } ref_t;

    localparam int n_rows = 18;

    logic            clk;
    logic            nrst;
    logic [ilen-1:0] fetch_word;
    logic            ext_stall;
    logic            fetch_stall;
    logic            id_valid;
    logic [ilen-1:0] id_inst;
    logic [ilen-1:0] id_pc;
    logic            id_compressed;
    logic            id_illegal;

    row_t tab [n_rows];
    ref_t exp_q [$];
    int   errors = 0;
    int   checked = 0;
    int   replays = 0;
    logic stall_last = 1'b0;

    tb_clk_gen u_clk (
        .clk (clk)
    );

    fetch_align_top u_dut (
        .clk           (clk),
        .nrst          (nrst),
        .fetch_word    (fetch_word),
        .ext_stall     (ext_stall),
        .fetch_stall   (fetch_stall),
        .id_valid      (id_valid),
        .id_inst       (id_inst),
        .id_pc         (id_pc),
        .id_compressed (id_compressed),
        .id_illegal    (id_illegal)
    );

    task automatic fill_table();
        // plain 32-bit run
        tab[0]  = '{32'h00100093, 2'd1, '{32'h00100093, 1'b0, 1'b0}, '0};
        tab[1]  = '{32'h002081B3, 2'd1, '{32'h002081B3, 1'b0, 1'b0}, '0};
        tab[2]  = '{32'h00032283, 2'd1, '{32'h00032283, 1'b0, 1'b0}, '0};
        // compressed pairs, low half first
        tab[3]  = '{32'h55F50515, 2'd2, '{32'h00550513, 1'b1, 1'b0}, '{32'hFFD00593, 1'b1, 1'b0}};
        tab[4]  = '{32'h86BA6605, 2'd2, '{32'h00001637, 1'b1, 1'b0}, '{32'h00E006B3, 1'b1, 1'b0}};
        tab[5]  = '{32'h404496BA, 2'd2, '{32'h00E686B3, 1'b1, 1'b0}, '{32'h00442483, 1'b1, 1'b0}};
        tab[6]  = '{32'hA021C404, 2'd2, '{32'h00942423, 1'b1, 1'b0}, '{32'h0080006F, 1'b1, 1'b0}};
        tab[7]  = '{32'hFCFDC011, 2'd2, '{32'h00040263, 1'b1, 1'b0}, '{32'hFE049FE3, 1'b1, 1'b0}};
        // c.jr is outside the subset
        tab[8]  = '{32'hBFF58082, 2'd2, '{32'h00000000, 1'b1, 1'b1}, '{32'hFFDFF06F, 1'b1, 1'b0}};
        tab[9]  = '{32'h00000000, 2'd0, '0, '0};
        // c.nop then two 32-bit instructions straddling word boundaries
        tab[10] = '{32'h00930001, 2'd1, '{32'h00000013, 1'b1, 1'b0}, '0};
        tab[11] = '{32'h00000000, 2'd0, '0, '0};
        tab[12] = '{32'h81B30010, 2'd1, '{32'h00100093, 1'b0, 1'b0}, '0};
        tab[13] = '{32'h00010020, 2'd2, '{32'h002081B3, 1'b0, 1'b0}, '{32'h00000013, 1'b1, 1'b0}};
        tab[14] = '{32'h00032283, 2'd1, '{32'h00032283, 1'b0, 1'b0}, '0};
        tab[15] = '{32'h00000000, 2'd0, '0, '0};
        tab[16] = '{32'h55F50515, 2'd2, '{32'h00550513, 1'b1, 1'b0}, '{32'hFFD00593, 1'b1, 1'b0}};
        tab[17] = '{32'h00100093, 2'd1, '{32'h00100093, 1'b0, 1'b0}, '0};
    endtask

    task automatic push_expected(input issue_t e, inout logic [ilen-1:0] pc_acc);
        exp_q.push_back(ref_t'{e.inst, pc_acc, e.c, e.i});
        pc_acc = pc_acc + (e.c ? 32'd2 : 32'd4);
    endtask

    task automatic check_word(input string name, input logic [ilen-1:0] got,
                              input logic [ilen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // outputs read before the edge; a stalled cycle only repeats the held item
    always @(posedge clk) begin
        ref_t r;
        if (nrst && id_valid && !stall_last) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR %0t: id_valid high with no instruction left to expect", $time);
            end else begin
                r = exp_q.pop_front();
                checked++;
                check_word("id_inst", id_inst, r.inst);
                check_word("id_pc", id_pc, r.pc);
                check_flag("id_compressed", id_compressed, r.c);
                check_flag("id_illegal", id_illegal, r.i);
            end
        end
        if (nrst && fetch_stall && !ext_stall) begin
            replays++;
        end
        stall_last <= ext_stall;
    end

    initial begin
        int              row_idx;
        int              exp_replays;
        logic [ilen-1:0] next_pc;
        nrst       = 1'b0;
        fetch_word = '0;
        ext_stall  = 1'b0;
        void'($urandom(32'ha61ce882));
        fill_table();
        next_pc     = reset_pc;
        exp_replays = 0;
        for (int k = 0; k < n_rows; k++) begin
            if (tab[k].n != 2'd0) begin
                push_expected(tab[k].e0, next_pc);
            end
            if (tab[k].n == 2'd2) begin
                push_expected(tab[k].e1, next_pc);
                // a buffered compressed upper half costs one replayed fetch
                if (tab[k].e1.c) begin
                    exp_replays++;
                end
            end
        end
        repeat (8) @(posedge clk);
        nrst       <= 1'b1;
        fetch_word <= tab[0].word;
        row_idx = 0;
        while (row_idx < n_rows) begin
            @(posedge clk);
            // word taken only if neither stall was up before this edge
            if (!ext_stall && !fetch_stall) begin
                row_idx++;
            end
            fetch_word <= (row_idx < n_rows) ? tab[row_idx].word : '0;
            ext_stall  <= ($urandom_range(3) == 0);
        end
        ext_stall <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // a few idle cycles to catch stray issues
        repeat (4) @(posedge clk);
        check_word("replay count", replays, exp_replays);
        $display("checked %0d instructions, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (n_rows * 4 + 200) @(posedge clk);
        $display("timeout: %0d expected instructions never reached decode", exp_q.size());
        $display("checked %0d instructions, %0d errors", checked, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
rtl/fetch_pkg.sv
rtl/compressed_buffer.sv
rtl/rvc_expander.sv
rtl/pc_sequencer.sv
rtl/id_latch.sv
rtl/fetch_align_top.sv
test/tb_clk_gen.sv
test/fetch_align_assert.sv
test/fetch_align_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = fetch_align_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

# the pipe returns the status of grep, so a missing pass line fails the target
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
